/* hw/core_pkg.sv */
package core_pkg;

    localparam int data_width = 32;
    localparam int reg_addr_width = 5;
    localparam int num_regs = 32;

    // major opcodes
    localparam logic [5:0] op_rtype = 6'h00;
    localparam logic [5:0] op_addiu = 6'h09;
    localparam logic [5:0] op_slti = 6'h0a;
    localparam logic [5:0] op_sltiu = 6'h0b;
    localparam logic [5:0] op_andi = 6'h0c;
    localparam logic [5:0] op_ori = 6'h0d;
    localparam logic [5:0] op_xori = 6'h0e;
    localparam logic [5:0] op_lui = 6'h0f;

    // r-type function field
    localparam logic [5:0] fn_sll = 6'h00;
    localparam logic [5:0] fn_srl = 6'h02;
    localparam logic [5:0] fn_sra = 6'h03;
    localparam logic [5:0] fn_addu = 6'h21;
    localparam logic [5:0] fn_subu = 6'h23;
    localparam logic [5:0] fn_and = 6'h24;
    localparam logic [5:0] fn_or = 6'h25;
    localparam logic [5:0] fn_xor = 6'h26;
    localparam logic [5:0] fn_nor = 6'h27;
    localparam logic [5:0] fn_slt = 6'h2a;
    localparam logic [5:0] fn_sltu = 6'h2b;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_nor,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_lui
    } alu_op_t;

    // decode to execute
    typedef struct packed {
        alu_op_t op;
        logic [data_width-1:0] operand_a;
        logic [data_width-1:0] operand_b;
        logic [4:0] shamt;
        logic [reg_addr_width-1:0] dest;
    } exec_req_t;

    // execute to result stage
    typedef struct packed {
        logic [reg_addr_width-1:0] dest;
        logic [data_width-1:0] value;
    } wb_req_t;

endpackage

/* hw/stage_if.sv */
`timescale 1ns/100ps

// four-phase req/ack link between two stages
interface stage_if #(
    parameter type payload_t = logic
) ();

    logic req;
    logic ack;
    payload_t payload;

    modport sender (
        output req,
        output payload,
        input ack
    );

    modport receiver (
        input req,
        input payload,
        output ack
    );

endinterface

/* hw/regfile.sv */
`timescale 1ns/100ps

module regfile (
    input  logic r_clk,
    input  logic reset,
    input  logic write_control,
    input  logic [core_pkg::reg_addr_width-1:0] read_reg1,
    input  logic [core_pkg::reg_addr_width-1:0] read_reg2,
    input  logic [core_pkg::reg_addr_width-1:0] write_reg,
    input  logic [core_pkg::data_width-1:0] write_data,
    output logic [core_pkg::data_width-1:0] read_data1,
    output logic [core_pkg::data_width-1:0] read_data2
);
    import core_pkg::*;

    logic [data_width-1:0] registers [0:num_regs-1];

    always_ff @(posedge r_clk) begin
        if (reset) begin
            for (int i = 0; i < num_regs; i++) begin
                registers[i] <= '0;
            end
        end else if (write_control && (write_reg != '0)) begin
            // writes to r0 are dropped
            registers[write_reg] <= write_data;
        end
    end

    assign read_data1 = (read_reg1 == '0) ? '0 : registers[read_reg1];
    assign read_data2 = (read_reg2 == '0) ? '0 : registers[read_reg2];

endmodule

/* hw/instr_decode.sv */
`timescale 1ns/100ps

module instr_decode (
    input  logic r_clk,
    input  logic reset,
    input  logic instr_req,
    input  logic [core_pkg::data_width-1:0] instr,
    output logic instr_ack,
    output logic [core_pkg::reg_addr_width-1:0] read_reg1,
    output logic [core_pkg::reg_addr_width-1:0] read_reg2,
    input  logic [core_pkg::data_width-1:0] read_data1,
    input  logic [core_pkg::data_width-1:0] read_data2,
    stage_if.sender exe
);
    import core_pkg::*;

    typedef enum logic [2:0] {
        s_idle,
        s_exe_ack,
        s_exe_ack_low,
        s_ack,
        s_req_low
    } state_t;

    state_t state;
    logic [5:0] opcode;
    logic [5:0] funct;
    logic [15:0] imm;
    logic [data_width-1:0] imm_sext;
    logic [data_width-1:0] imm_zext;
    exec_req_t decoded;
    logic supported;

    assign opcode = instr[31:26];
    assign funct = instr[5:0];
    assign imm = instr[15:0];
    assign read_reg1 = instr[25:21];
    assign read_reg2 = instr[20:16];
    assign imm_sext = {{(data_width-16){imm[15]}}, imm};
    assign imm_zext = {{(data_width-16){1'b0}}, imm};

    always_comb begin
        supported = 1'b1;
        decoded.op = alu_add;
        decoded.operand_a = read_data1;
        decoded.operand_b = read_data2;
        decoded.shamt = instr[10:6];
        decoded.dest = instr[15:11];
        if (opcode == op_rtype) begin
            case (funct)
                fn_sll: decoded.op = alu_sll;
                fn_srl: decoded.op = alu_srl;
                fn_sra: decoded.op = alu_sra;
                fn_addu: decoded.op = alu_add;
                fn_subu: decoded.op = alu_sub;
                fn_and: decoded.op = alu_and;
                fn_or: decoded.op = alu_or;
                fn_xor: decoded.op = alu_xor;
                fn_nor: decoded.op = alu_nor;
                fn_slt: decoded.op = alu_slt;
                fn_sltu: decoded.op = alu_sltu;
                default: supported = 1'b0;
            endcase
        end else begin
            // i-type targets rt, logic ops zero-extend
            decoded.dest = instr[20:16];
            decoded.operand_b = imm_zext;
            case (opcode)
                op_addiu: begin
                    decoded.op = alu_add;
                    decoded.operand_b = imm_sext;
                end
                op_slti: begin
                    decoded.op = alu_slt;
                    decoded.operand_b = imm_sext;
                end
                op_sltiu: begin
                    decoded.op = alu_sltu;
                    decoded.operand_b = imm_sext;
                end
                op_andi: decoded.op = alu_and;
                op_ori: decoded.op = alu_or;
                op_xori: decoded.op = alu_xor;
                op_lui: decoded.op = alu_lui;
                default: supported = 1'b0;
            endcase
        end
    end

    always_ff @(posedge r_clk) begin
        if (reset) begin
            state <= s_idle;
            instr_ack <= 1'b0;
            exe.req <= 1'b0;
            exe.payload <= '0;
        end else begin
            case (state)
                s_idle: begin
                    if (instr_req) begin
                        if (supported) begin
                            exe.payload <= decoded;
                            exe.req <= 1'b1;
                            state <= s_exe_ack;
                        end else begin
                            // nothing to execute, just acknowledge
                            state <= s_ack;
                        end
                    end
                end
                s_exe_ack: begin
                    if (exe.ack) begin
                        exe.req <= 1'b0;
                        state <= s_exe_ack_low;
                    end
                end
                s_exe_ack_low: begin
                    if (!exe.ack) begin
                        state <= s_ack;
                    end
                end
                s_ack: begin
                    instr_ack <= 1'b1;
                    state <= s_req_low;
                end
                s_req_low: begin
                    if (!instr_req) begin
                        instr_ack <= 1'b0;
                        state <= s_idle;
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

endmodule

/* hw/alu_execute.sv */
`timescale 1ns/100ps

module alu_execute (
    input  logic r_clk,
    input  logic reset,
    stage_if.receiver dec,
    stage_if.sender wb
);
    import core_pkg::*;

    typedef enum logic [1:0] {
        s_idle,
        s_wb_ack,
        s_wb_ack_low,
        s_req_low
    } state_t;

    state_t state;
    exec_req_t cur;
    logic [data_width-1:0] result;

    assign cur = dec.payload;

    always_comb begin
        case (cur.op)
            alu_add: result = cur.operand_a + cur.operand_b;
            alu_sub: result = cur.operand_a - cur.operand_b;
            alu_and: result = cur.operand_a & cur.operand_b;
            alu_or: result = cur.operand_a | cur.operand_b;
            alu_xor: result = cur.operand_a ^ cur.operand_b;
            alu_nor: result = ~(cur.operand_a | cur.operand_b);
            alu_slt: begin
                result = {{(data_width-1){1'b0}},
                          $signed(cur.operand_a) < $signed(cur.operand_b)};
            end
            alu_sltu: begin
                result = {{(data_width-1){1'b0}}, cur.operand_a < cur.operand_b};
            end
            // shifts act on rt
            alu_sll: result = cur.operand_b << cur.shamt;
            alu_srl: result = cur.operand_b >> cur.shamt;
            alu_sra: result = $signed(cur.operand_b) >>> cur.shamt;
            alu_lui: result = {cur.operand_b[15:0], {(data_width-16){1'b0}}};
            default: result = '0;
        endcase
    end

    always_ff @(posedge r_clk) begin
        if (reset) begin
            state <= s_idle;
            dec.ack <= 1'b0;
            wb.req <= 1'b0;
            wb.payload <= '0;
        end else begin
            case (state)
                s_idle: begin
                    if (dec.req) begin
                        wb.payload.dest <= cur.dest;
                        wb.payload.value <= result;
                        wb.req <= 1'b1;
                        state <= s_wb_ack;
                    end
                end
                s_wb_ack: begin
                    if (wb.ack) begin
                        wb.req <= 1'b0;
                        state <= s_wb_ack_low;
                    end
                end
                s_wb_ack_low: begin
                    // result stage done, release decode
                    if (!wb.ack) begin
                        dec.ack <= 1'b1;
                        state <= s_req_low;
                    end
                end
                s_req_low: begin
                    if (!dec.req) begin
                        dec.ack <= 1'b0;
                        state <= s_idle;
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

endmodule

/* hw/result_writeback.sv */
`timescale 1ns/100ps

module result_writeback (
    input  logic r_clk,
    input  logic reset,
    stage_if.receiver exe,
    output logic res_req,
    output logic [core_pkg::reg_addr_width-1:0] res_dest,
    output logic [core_pkg::data_width-1:0] res_data,
    input  logic res_ack,
    output logic write_control,
    output logic [core_pkg::reg_addr_width-1:0] write_reg,
    output logic [core_pkg::data_width-1:0] write_data
);
    import core_pkg::*;

    typedef enum logic [1:0] {
        s_idle,
        s_res_ack,
        s_res_ack_low,
        s_req_low
    } state_t;

    state_t state;

    // write lands on the edge where res_ack is first seen
    assign write_control = (state == s_res_ack) && res_ack;
    assign write_reg = res_dest;
    assign write_data = res_data;

    always_ff @(posedge r_clk) begin
        if (reset) begin
            state <= s_idle;
            exe.ack <= 1'b0;
            res_req <= 1'b0;
            res_dest <= '0;
            res_data <= '0;
        end else begin
            case (state)
                s_idle: begin
                    if (exe.req) begin
                        res_dest <= exe.payload.dest;
                        res_data <= exe.payload.value;
                        res_req <= 1'b1;
                        state <= s_res_ack;
                    end
                end
                s_res_ack: begin
                    if (res_ack) begin
                        res_req <= 1'b0;
                        state <= s_res_ack_low;
                    end
                end
                s_res_ack_low: begin
                    if (!res_ack) begin
                        exe.ack <= 1'b1;
                        state <= s_req_low;
                    end
                end
                s_req_low: begin
                    if (!exe.req) begin
                        exe.ack <= 1'b0;
                        state <= s_idle;
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

endmodule

/* hw/mips_alu_core.sv */
`timescale 1ns/100ps

module mips_alu_core (
    input  logic r_clk,
    input  logic reset,
    input  logic instr_req,
    input  logic [core_pkg::data_width-1:0] instr,
    output logic instr_ack,
    output logic res_req,
    output logic [core_pkg::reg_addr_width-1:0] res_dest,
    output logic [core_pkg::data_width-1:0] res_data,
    input  logic res_ack
);
    import core_pkg::*;

    logic [reg_addr_width-1:0] read_reg1;
    logic [reg_addr_width-1:0] read_reg2;
    logic [data_width-1:0] read_data1;
    logic [data_width-1:0] read_data2;
    logic write_control;
    logic [reg_addr_width-1:0] write_reg;
    logic [data_width-1:0] write_data;

    stage_if #(.payload_t(exec_req_t)) dec_exe ();
    stage_if #(.payload_t(wb_req_t)) exe_wb ();

    regfile regfile_i (
        .r_clk(r_clk),
        .reset(reset),
        .write_control(write_control),
        .read_reg1(read_reg1),
        .read_reg2(read_reg2),
        .write_reg(write_reg),
        .write_data(write_data),
        .read_data1(read_data1),
        .read_data2(read_data2)
    );

    instr_decode decode_i (
        .r_clk(r_clk),
        .reset(reset),
        .instr_req(instr_req),
        .instr(instr),
        .instr_ack(instr_ack),
        .read_reg1(read_reg1),
        .read_reg2(read_reg2),
        .read_data1(read_data1),
        .read_data2(read_data2),
        .exe(dec_exe.sender)
    );

    alu_execute execute_i (
        .r_clk(r_clk),
        .reset(reset),
        .dec(dec_exe.receiver),
        .wb(exe_wb.sender)
    );

    result_writeback writeback_i (
        .r_clk(r_clk),
        .reset(reset),
        .exe(exe_wb.receiver),
        .res_req(res_req),
        .res_dest(res_dest),
        .res_data(res_data),
        .res_ack(res_ack),
        .write_control(write_control),
        .write_reg(write_reg),
        .write_data(write_data)
    );

endmodule

/* tests/core_checker.sv */
`timescale 1ns/100ps

module core_checker (
    input  logic r_clk,
    input  logic reset,
    input  logic instr_req,
    input  logic [core_pkg::data_width-1:0] instr,
    input  logic instr_ack,
    input  logic res_req,
    input  logic [core_pkg::reg_addr_width-1:0] res_dest,
    input  logic [core_pkg::data_width-1:0] res_data,
    input  logic res_ack,
    output int error_count,
    output int instr_count,
    output int result_count
);
    import core_pkg::*;

    logic [data_width-1:0] model_regs [0:num_regs-1];
    logic prev_instr_req;
    logic prev_instr_ack;
    logic prev_res_req;
    logic prev_res_ack;
    logic pending;
    logic exp_valid;
    logic got_result;
    logic [reg_addr_width-1:0] exp_dest;
    logic [data_width-1:0] exp_value;
    logic [reg_addr_width-1:0] held_dest;
    logic [data_width-1:0] held_data;

    task automatic value_mismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        $display("FAILED %s: expected %h, actual %h", name, expected, actual);
        error_count++;
    endtask

    task automatic protocol_error(input string msg);
        $display("at %0t: %s", $time, msg);
        error_count++;
    endtask

    // reference decode and ALU from the MIPS field layout
    task automatic predict_result(input logic [31:0] word, input logic [31:0] rs_val,
                                  input logic [31:0] rt_val, output logic ok,
                                  output logic [4:0] dest, output logic [31:0] value);
        logic [31:0] sext;
        logic [31:0] zext;
        logic [4:0] sa;
        sext = {{16{word[15]}}, word[15:0]};
        zext = {16'h0000, word[15:0]};
        sa = word[10:6];
        ok = 1'b1;
        value = '0;
        dest = word[20:16];
        if (word[31:26] == op_rtype) begin
            dest = word[15:11];
            case (word[5:0])
                fn_addu: value = rs_val + rt_val;
                fn_subu: value = rs_val - rt_val;
                fn_and: value = rs_val & rt_val;
                fn_or: value = rs_val | rt_val;
                fn_xor: value = rs_val ^ rt_val;
                fn_nor: value = ~(rs_val | rt_val);
                fn_slt: value = ($signed(rs_val) < $signed(rt_val)) ? 32'd1 : 32'd0;
                fn_sltu: value = (rs_val < rt_val) ? 32'd1 : 32'd0;
                fn_sll: value = rt_val << sa;
                fn_srl: value = rt_val >> sa;
                fn_sra: value = $signed(rt_val) >>> sa;
                default: ok = 1'b0;
            endcase
        end else begin
            case (word[31:26])
                op_addiu: value = rs_val + sext;
                op_slti: value = ($signed(rs_val) < $signed(sext)) ? 32'd1 : 32'd0;
                op_sltiu: value = (rs_val < sext) ? 32'd1 : 32'd0;
                op_andi: value = rs_val & zext;
                op_ori: value = rs_val | zext;
                op_xori: value = rs_val ^ zext;
                op_lui: value = {word[15:0], 16'h0000};
                default: ok = 1'b0;
            endcase
        end
    endtask

    always @(posedge r_clk) begin
        if (reset) begin
            model_regs = '{default: '0};
            {prev_instr_req, prev_instr_ack, prev_res_req, prev_res_ack} = 4'b0000;
            {pending, exp_valid, got_result} = 3'b000;
            error_count = 0;
            instr_count = 0;
            result_count = 0;
        end else begin
            if (instr_req && !prev_instr_req) begin
                if (instr_ack)
                    protocol_error("instr_req rose while instr_ack was still high");
                if (pending)
                    protocol_error("new instruction before the previous one was acknowledged");
                predict_result(instr, model_regs[instr[25:21]], model_regs[instr[20:16]],
                               exp_valid, exp_dest, exp_value);
                pending = 1'b1;
                got_result = 1'b0;
                instr_count++;
            end
            if (res_req && !prev_res_req) begin
                result_count++;
                if (prev_res_ack)
                    protocol_error("res_req rose while res_ack was still high");
                if (!pending || !exp_valid) begin
                    protocol_error("result appeared without a matching instruction");
                end else if (got_result) begin
                    protocol_error("second result for one instruction");
                end else begin
                    if (res_dest != exp_dest)
                        value_mismatch("res_dest", 32'(exp_dest), 32'(res_dest));
                    if (res_data != exp_value)
                        value_mismatch("res_data", exp_value, res_data);
                    got_result = 1'b1;
                end
                held_dest = res_dest;
                held_data = res_data;
            end else if (res_req) begin
                if (res_dest != held_dest)
                    value_mismatch("res_dest", 32'(held_dest), 32'(res_dest));
                if (res_data != held_data)
                    value_mismatch("res_data", held_data, res_data);
            end
            // accepted result updates the model except for r0
            if (res_ack && !prev_res_ack && res_req && got_result && exp_dest != '0)
                model_regs[exp_dest] = exp_value;
            if (instr_ack && !prev_instr_ack) begin
                if (!pending)
                    protocol_error("instr_ack rose with no instruction outstanding");
                else if (exp_valid && !got_result)
                    protocol_error("instruction was acknowledged without a result");
                if (res_req || res_ack)
                    protocol_error("instr_ack rose before the result exchange ended");
                pending = 1'b0;
            end
            prev_instr_req = instr_req;
            prev_instr_ack = instr_ack;
            prev_res_req = res_req;
            prev_res_ack = res_ack;
        end
    end

endmodule

/* tests/tb_mips_alu_core.sv */
`timescale 1ns/100ps

module tb_mips_alu_core;
    import core_pkg::*;

    localparam int num_instr = 400;
    localparam int timeout_cycles = num_instr * 40;

    logic r_clk;
    logic reset;
    logic instr_req;
    logic [data_width-1:0] instr;
    logic instr_ack;
    logic res_req;
    logic [reg_addr_width-1:0] res_dest;
    logic [data_width-1:0] res_data;
    logic res_ack;
    int error_count;
    int instr_count;
    int result_count;
    int cycle_count = 0;
    logic [31:0] instr_seed = 32'ha88f_33b9;
    logic [31:0] delay_seed = 32'ha88f_33b9 ^ 32'h5a5a_0f0f;

    mips_alu_core dut_i (.*);

    core_checker checker_i (.*);

    initial r_clk = 1'b0;
    always #10 r_clk = ~r_clk;

    always @(posedge r_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout: run did not finish within %0d cycles", timeout_cycles);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // mostly r0 to r7 so results feed later instructions
    function automatic logic [4:0] pick_reg(input logic [5:0] r);
        return r[5] ? r[4:0] : {2'b00, r[2:0]};
    endfunction

    function automatic logic [31:0] random_instr(input logic [31:0] r1, input logic [31:0] r2);
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [5:0] code;
        rs = pick_reg(r1[27:22]);
        rt = pick_reg(r1[21:16]);
        rd = pick_reg(r1[15:10]);
        if (r1[31:28] < 4'd9) begin
            case (r1[9:6])
                4'd0: code = fn_sll;
                4'd1: code = fn_srl;
                4'd2, 4'd11: code = fn_sra;
                4'd3: code = fn_addu;
                4'd4, 4'd12: code = fn_subu;
                4'd5: code = fn_and;
                4'd6: code = fn_or;
                4'd7: code = fn_xor;
                4'd8: code = fn_nor;
                4'd9, 4'd13: code = fn_slt;
                default: code = fn_sltu;
            endcase
            return {op_rtype, rs, rt, rd, r2[31:27], code};
        end else if (r1[31:28] < 4'd14) begin
            case (r1[5:3])
                3'd0: code = op_addiu;
                3'd1: code = op_slti;
                3'd2: code = op_sltiu;
                3'd3: code = op_andi;
                3'd4: code = op_ori;
                3'd5: code = op_xori;
                3'd6: code = op_lui;
                default: code = op_addiu;
            endcase
            return {code, rs, rt, r2[15:0]};
        end else if (r1[28]) begin
            // r-type with an unsupported function code
            case (r1[8:6])
                3'd0: code = 6'h08;
                3'd1: code = 6'h09;
                3'd2: code = 6'h10;
                3'd3: code = 6'h12;
                3'd4: code = 6'h18;
                3'd5: code = 6'h1a;
                3'd6: code = 6'h20;
                default: code = 6'h22;
            endcase
            return {op_rtype, rs, rt, rd, r2[31:27], code};
        end else begin
            case (r1[8:6])
                3'd0: code = 6'h02;
                3'd1: code = 6'h03;
                3'd2: code = 6'h04;
                3'd3: code = 6'h05;
                3'd4: code = 6'h08;
                3'd5: code = 6'h23;
                3'd6: code = 6'h2b;
                default: code = 6'h3f;
            endcase
            return {code, r2[25:0]};
        end
    endfunction

    // called on a falling edge with instr_ack low
    task automatic send_instr(input logic [31:0] word);
        instr = word;
        instr_req = 1'b1;
        do @(negedge r_clk); while (!instr_ack);
        instr_req = 1'b0;
        do @(negedge r_clk); while (instr_ack);
    endtask

    task automatic wait_random_cycles();
        delay_seed = lcg_next(delay_seed);
        repeat (delay_seed[31:30]) @(negedge r_clk);
    endtask

    // result channel responder
    initial begin
        res_ack = 1'b0;
        forever begin
            @(negedge r_clk);
            if (!reset && res_req) begin
                wait_random_cycles();
                res_ack = 1'b1;
                do @(negedge r_clk); while (res_req);
                wait_random_cycles();
                res_ack = 1'b0;
            end
        end
    end

    initial begin
        logic [4:0] r;
        logic [31:0] r1;
        reset = 1'b1;
        instr_req = 1'b0;
        instr = '0;
        repeat (4) @(posedge r_clk);
        @(negedge r_clk);
        reset = 1'b0;
        // or rX, rX, rX reads back every register after reset
        for (int i = 0; i < num_regs; i++) begin
            r = 5'(i);
            send_instr({op_rtype, r, r, r, 5'd0, fn_or});
        end
        for (int i = num_regs; i < num_instr; i++) begin
            instr_seed = lcg_next(instr_seed);
            r1 = instr_seed;
            instr_seed = lcg_next(instr_seed);
            send_instr(random_instr(r1, instr_seed));
        end
        repeat (4) @(negedge r_clk);
        $display("instructions %0d, results %0d, errors %0d",
                 instr_count, result_count, error_count);
        if (error_count == 0 && instr_count == num_instr) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* verilog.f */
hw/core_pkg.sv
hw/stage_if.sv
hw/regfile.sv
hw/instr_decode.sv
hw/alu_execute.sv
hw/result_writeback.sv
hw/mips_alu_core.sv
tests/core_checker.sv
tests/tb_mips_alu_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary -j 0 --top-module tb_mips_alu_core -f verilog.f -o tb_mips_alu_core
./obj_dir/tb_mips_alu_core | tee sim.log

if grep -qx "RESULT: PASS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
